/* Makefile */
VERILATOR := verilator
VFLAGS    := --binary --timing --assert -Wno-fatal -j 0
TOP       := tb_dma_top
FILELIST  := files.f
OBJDIR    := obj_dir
PASS_MSG  := NO ERRORS

SIM     := $(OBJDIR)/V$(TOP)
SOURCES := $(shell cat $(FILELIST))

.PHONY: all run clean

all: $(SIM)

# Rebuilt only when a source or the file list changes
$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)

# Passes only when the pass line shows up in the output
run: $(SIM)
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJDIR)

/* files.f */
hdl/dma_pkg.sv
hdl/dma_local_mem.sv
hdl/dma_bus_arbiter.sv
hdl/dma_read_engine.sv
hdl/dma_ctrl_regs.sv
hdl/dma_top.sv
tb/tb_dma_top.sv

/* hdl/dma_bus_arbiter.sv */
`timescale 1ns/100ps
`default_nettype none

module dma_bus_arbiter
  import dma_pkg::*;
#(
  parameter int ADDR_WIDTH = 32,
  parameter int DATA_WIDTH = 32
) (
  input  logic                  clk,
  input  logic                  rst,
  // Engine 0
  input  logic                  m0_hsel,
  input  logic [ADDR_WIDTH-1:0] m0_haddr,
  input  logic [2:0]            m0_hburst,
  input  logic                  m0_hmastlock,
  output logic [DATA_WIDTH-1:0] m0_hrdata,
  output logic                  m0_hready,
  // Engine 1
  input  logic                  m1_hsel,
  input  logic [ADDR_WIDTH-1:0] m1_haddr,
  input  logic [2:0]            m1_hburst,
  input  logic                  m1_hmastlock,
  output logic [DATA_WIDTH-1:0] m1_hrdata,
  output logic                  m1_hready,
  // Toward the memory
  output logic                  s_hsel,
  output logic [ADDR_WIDTH-1:0] s_haddr,
  input  logic [DATA_WIDTH-1:0] s_hrdata,
  input  logic                  s_hready
);

  // Current owner of the bus
  logic       grant;
  logic       owner_lock;
  logic       other_req;
  logic [2:0] owner_burst;

  assign owner_lock  = grant ? m1_hmastlock : m0_hmastlock;
  assign owner_burst = grant ? m1_hburst : m0_hburst;
  assign other_req   = grant ? m0_hsel : m1_hsel;

  // Hand over only between bursts and only to a waiting peer
  // Two engines make this plain round robin
  always_ff @(posedge clk) begin
    if (rst) begin
      grant <= 1'b0;
    end else if (!owner_lock && other_req) begin
      grant <= ~grant;
    end
  end

  //////////////////////////////
  // Request mux
  //////////////////////////////

  assign s_hsel  = grant ? m1_hsel : m0_hsel;
  assign s_haddr = grant ? m1_haddr : m0_haddr;

  // Read data is shared, hready goes to the owner alone
  assign m0_hrdata = s_hrdata;
  assign m1_hrdata = s_hrdata;
  assign m0_hready = s_hready & ~grant;
  assign m1_hready = s_hready & grant;

  // Locked bursts keep the bus
  a_lock_grant: assert property (@(posedge clk) disable iff (rst)
    owner_lock |=> $stable(grant));

  // An INCR beat is followed by another beat of the same burst
  a_incr_next: assert property (@(posedge clk) disable iff (rst)
    s_hsel && s_hready && owner_burst == HBURST_INCR |=> s_hsel && $stable(grant));

endmodule

`default_nettype wire

/* hdl/dma_ctrl_regs.sv */
`timescale 1ns/100ps
`default_nettype none

module dma_ctrl_regs
  import dma_pkg::*;
#(
  parameter int ADDR_WIDTH = 32,
  parameter int DATA_WIDTH = 32,
  parameter int MEM_WORDS  = 256
) (
  input  logic                         clk,
  input  logic                         rst,
  // AXI4-Lite slave
  input  logic                         awvalid,
  output logic                         awready,
  input  logic [ADDR_WIDTH-1:0]        awaddr,
  input  logic                         wvalid,
  output logic                         wready,
  input  logic [DATA_WIDTH-1:0]        wdata,
  output logic                         bvalid,
  input  logic                         bready,
  output logic [1:0]                   bresp,
  input  logic                         arvalid,
  output logic                         arready,
  input  logic [ADDR_WIDTH-1:0]        araddr,
  output logic                         rvalid,
  input  logic                         rready,
  output logic [DATA_WIDTH-1:0]        rdata,
  output logic [1:0]                   rresp,
  // Channel 0
  output logic                         ch0_start,
  output logic [ADDR_WIDTH-1:0]        ch0_laddr,
  output logic [DMA_SIZE_WIDTH-1:0]    ch0_size,
  input  logic                         ch0_idle,
  input  logic                         ch0_fifo_empty,
  // Channel 1
  output logic                         ch1_start,
  output logic [ADDR_WIDTH-1:0]        ch1_laddr,
  output logic [DMA_SIZE_WIDTH-1:0]    ch1_size,
  input  logic                         ch1_idle,
  input  logic                         ch1_fifo_empty,
  // Memory window writes
  output logic                         mem_wr_en,
  output logic [$clog2(MEM_WORDS)-1:0] mem_wr_index,
  output logic [DATA_WIDTH-1:0]        mem_wr_data
);

  localparam int OFS_W = $clog2(DMA_CH_STRIDE);
  localparam int IDX_W = $clog2(MEM_WORDS);

  logic [ADDR_WIDTH-1:0]     laddr_q [2];
  logic [DMA_SIZE_WIDTH-1:0] size_q [2];
  logic [1:0]                busy;
  logic [1:0]                start_q;
  logic [1:0]                idle_in;
  logic [1:0]                empty_in;
  logic                      wr_fire;
  logic                      wr_win;
  logic                      wr_ch;
  logic [OFS_W-1:0]          wr_ofs;
  logic                      rd_fire;
  logic                      rd_ch;
  logic [OFS_W-1:0]          rd_ofs;
  logic                      rvalid_nxt;
  logic [DATA_WIDTH-1:0]     rd_word;

  assign idle_in  = {ch1_idle, ch0_idle};
  assign empty_in = {ch1_fifo_empty, ch0_fifo_empty};

  assign ch0_start = start_q[0];
  assign ch1_start = start_q[1];
  assign ch0_laddr = laddr_q[0];
  assign ch1_laddr = laddr_q[1];
  assign ch0_size  = size_q[0];
  assign ch1_size  = size_q[1];

  //////////////////////////////
  // Write path
  //////////////////////////////

  // Address and data are taken together in one cycle
  assign wr_fire = awvalid & wvalid & ~bvalid;
  assign awready = wr_fire;
  assign wready  = wr_fire;
  assign wr_win  = awaddr[DMA_MEM_WINDOW_BIT];
  assign wr_ch   = awaddr[OFS_W];
  assign wr_ofs  = awaddr[OFS_W-1:0];

  // Always OKAY
  assign bresp = 2'b00;

  always_ff @(posedge clk) begin
    if (rst) begin
      bvalid <= 1'b0;
    end else if (wr_fire) begin
      bvalid <= 1'b1;
    end else if (bready) begin
      bvalid <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    for (int c = 0; c < 2; c++) begin
      if (rst) begin
        laddr_q[c] <= '0;
        size_q[c]  <= '0;
        start_q[c] <= 1'b0;
        busy[c]    <= 1'b0;
      end else begin
        if (wr_fire && !wr_win && wr_ch == 1'(c)) begin
          if (wr_ofs == DMA_REG_LADDR) begin
            laddr_q[c] <= wdata[ADDR_WIDTH-1:0];
          end
          if (wr_ofs == DMA_REG_SIZE) begin
            size_q[c] <= wdata[DMA_SIZE_WIDTH-1:0];
          end
        end
        // Start only an idle channel with a real length
        start_q[c] <= wr_fire && !wr_win && wr_ch == 1'(c) && wr_ofs == DMA_REG_CTRL &&
                      wdata[0] && !busy[c] && size_q[c] != '0;
        // Busy until the last word has left the stream
        if (start_q[c]) begin
          busy[c] <= 1'b1;
        end else if (idle_in[c] && empty_in[c]) begin
          busy[c] <= 1'b0;
        end
      end
    end
  end

  // Window write goes out one cycle after the handshake
  always_ff @(posedge clk) begin
    if (rst) begin
      mem_wr_en <= 1'b0;
    end else begin
      mem_wr_en <= wr_fire & wr_win;
    end
  end

  always_ff @(posedge clk) begin
    mem_wr_index <= awaddr[IDX_W+1:2];
    mem_wr_data  <= wdata;
  end

  //////////////////////////////
  // Read path
  //////////////////////////////

  assign rd_fire    = arvalid & arready;
  assign rd_ch      = araddr[OFS_W];
  assign rd_ofs     = araddr[OFS_W-1:0];
  assign rvalid_nxt = rd_fire | (rvalid & ~rready);
  assign rresp      = 2'b00;

  // arready follows the empty response slot
  always_ff @(posedge clk) begin
    if (rst) begin
      rvalid  <= 1'b0;
      arready <= 1'b0;
    end else begin
      rvalid  <= rvalid_nxt;
      arready <= ~rvalid_nxt;
    end
  end

  // Memory window reads return zero
  always_comb begin
    rd_word = '0;
    if (!araddr[DMA_MEM_WINDOW_BIT]) begin
      case (rd_ofs)
        DMA_REG_LADDR: rd_word = DATA_WIDTH'(laddr_q[rd_ch]);
        DMA_REG_SIZE:  rd_word = DATA_WIDTH'(size_q[rd_ch]);
        DMA_REG_CTRL:  rd_word = DATA_WIDTH'(busy[rd_ch]);
        default:       rd_word = '0;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (rd_fire) begin
      rdata <= rd_word;
    end
  end

  // A busy channel is never restarted
  for (genvar c = 0; c < 2; c++) begin : g_chk
    a_no_restart: assert property (@(posedge clk) disable iff (rst)
      busy[c] |-> !start_q[c]);
  end

endmodule

`default_nettype wire

/* hdl/dma_local_mem.sv */
`timescale 1ns/100ps
`default_nettype none

module dma_local_mem #(
  parameter int ADDR_WIDTH = 32,
  parameter int DATA_WIDTH = 32,
  parameter int MEM_WORDS  = 256
) (
  input  logic                         clk,
  input  logic                         rst,
  // Bus read port
  input  logic                         hsel,
  input  logic [ADDR_WIDTH-1:0]        haddr,
  output logic [DATA_WIDTH-1:0]        hrdata,
  output logic                         hready,
  // Host write port
  input  logic                         wr_en,
  input  logic [$clog2(MEM_WORDS)-1:0] wr_index,
  input  logic [DATA_WIDTH-1:0]        wr_data
);

  localparam int IDX_W = $clog2(MEM_WORDS);

  logic [DATA_WIDTH-1:0] mem [MEM_WORDS];
  logic [DATA_WIDTH-1:0] rd_q;
  logic [IDX_W-1:0]      rd_index;
  logic                  pending;

  // Word index from the byte address
  assign rd_index = haddr[IDX_W+1:2];

  // One wait state per beat
  // The beat's own data cycle does not start a new access
  always_ff @(posedge clk) begin
    if (rst) begin
      pending <= 1'b0;
    end else begin
      pending <= hsel & ~pending;
    end
  end

  always_ff @(posedge clk) begin
    if (hsel && !pending) begin
      rd_q <= mem[rd_index];
    end
    if (wr_en) begin
      mem[wr_index] <= wr_data;
    end
  end

  assign hready = pending;
  assign hrdata = rd_q;

endmodule

`default_nettype wire

/* hdl/dma_pkg.sv */
`default_nettype none

package dma_pkg;

  // Transfer length in words
  localparam int DMA_SIZE_WIDTH = 10;

  // Byte distance between two channel register blocks
  localparam int DMA_CH_STRIDE = 16;

  // Register offsets inside one channel block
  localparam logic [3:0] DMA_REG_LADDR = 4'h0;
  localparam logic [3:0] DMA_REG_SIZE  = 4'h4;
  localparam logic [3:0] DMA_REG_CTRL  = 4'h8;

  // Host address bit that selects the memory window
  localparam int DMA_MEM_WINDOW_BIT = 11;

  // Burst codes on the memory bus
  // INCR keeps the burst going, TERM tags its last beat
  localparam logic [2:0] HBURST_INCR = 3'b010;
  localparam logic [2:0] HBURST_TERM = 3'b111;

endpackage

`default_nettype wire

/* hdl/dma_read_engine.sv */
`timescale 1ns/100ps
`default_nettype none

module dma_read_engine
  import dma_pkg::*;
#(
  parameter int ADDR_WIDTH = 32,
  parameter int DATA_WIDTH = 32
) (
  input  logic                      clk,
  input  logic                      rst,
  // Channel request
  input  logic                      start,
  input  logic [ADDR_WIDTH-1:0]     laddr,
  input  logic [DMA_SIZE_WIDTH-1:0] size,
  output logic                      idle,
  // Memory bus master side
  output logic                      hsel,
  output logic [ADDR_WIDTH-1:0]     haddr,
  output logic [2:0]                hburst,
  output logic                      hmastlock,
  input  logic [DATA_WIDTH-1:0]     hrdata,
  input  logic                      hready,
  // Output stream
  output logic                      data_valid,
  output logic [DATA_WIDTH-1:0]     data,
  input  logic                      data_ready
);

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_DATA,
    ST_WAIT
  } state_t;

  state_t                    state;
  state_t                    state_nxt;
  logic [DMA_SIZE_WIDTH-1:0] remain;
  logic [ADDR_WIDTH-1:0]     addr_q;
  logic                      last;

  // Three entry FIFO between bus and stream
  logic [DATA_WIDTH-1:0]     fifo_q [3];
  logic [3:0]                pos;
  logic                      push;
  logic                      pop;
  logic                      fifo_empty;
  logic                      fifo_ready;

  //////////////////////////////
  // Output FIFO
  //////////////////////////////

  // One-hot write position
  // bit 0 means empty and bit 3 means all three held
  assign fifo_empty = pos[0];
  assign data_valid = ~fifo_empty;
  assign data       = fifo_q[0];
  assign pop        = data_ready & ~fifo_empty;

  // High-water mark at two entries
  // Leaves room for the beat that is still on the bus
  assign fifo_ready = ~|pos[3:2];

  always_ff @(posedge clk) begin
    if (rst) begin
      pos <= 4'b0001;
    end else if (push && !pop) begin
      pos <= pos << 1;
    end else if (!push && pop) begin
      pos <= pos >> 1;
    end
  end

  // Head is slot 0 and everything shifts down on a pop
  always_ff @(posedge clk) begin
    for (int i = 0; i < 2; i++) begin
      if (pop) begin
        fifo_q[i] <= (push && pos[i+1]) ? hrdata : fifo_q[i+1];
      end else if (push && pos[i]) begin
        fifo_q[i] <= hrdata;
      end
    end
    // Top slot only fills, it never shifts in
    if (push && pos[2] && !pop) begin
      fifo_q[2] <= hrdata;
    end
  end

  //////////////////////////////
  // Burst FSM
  //////////////////////////////

  assign idle      = (state == ST_IDLE);
  assign hsel      = (state == ST_DATA);
  assign hmastlock = (state == ST_DATA);
  assign haddr     = addr_q;
  assign last      = (remain == DMA_SIZE_WIDTH'(1));
  assign push      = hsel & hready;

  // Close the burst on the final word or when the FIFO is near full
  assign hburst = (last || !fifo_ready) ? HBURST_TERM : HBURST_INCR;

  always_comb begin
    state_nxt = state;
    case (state)
      ST_IDLE: begin
        // FIFO is always empty here so go straight to the bus
        if (start) begin
          state_nxt = ST_DATA;
        end
      end
      ST_DATA: begin
        if (hready) begin
          if (last) begin
            state_nxt = ST_IDLE;
          end else if (!fifo_ready) begin
            state_nxt = ST_WAIT;
          end
        end
      end
      ST_WAIT: begin
        // Restart the burst once the stream drained
        if (fifo_ready) begin
          state_nxt = ST_DATA;
        end
      end
      default: begin
        state_nxt = ST_IDLE;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state  <= ST_IDLE;
      remain <= '0;
    end else begin
      state <= state_nxt;
      // Words still to fetch
      if (idle && start) begin
        remain <= size;
      end else if (push) begin
        remain <= remain - 1'b1;
      end
    end
  end

  // Word address walks up from the start address
  always_ff @(posedge clk) begin
    if (idle && start) begin
      addr_q <= laddr;
    end else if (push) begin
      addr_q <= addr_q + ADDR_WIDTH'(4);
    end
  end

  // FSM must never fill a full FIFO
  a_no_overflow: assert property (@(posedge clk) disable iff (rst)
    push |-> !pos[3]);

  // A stalled beat keeps its request until the memory answers
  a_hold_addr: assert property (@(posedge clk) disable iff (rst)
    hsel && !hready |=> hsel && $stable(haddr));

endmodule

`default_nettype wire

/* hdl/dma_top.sv */
`timescale 1ns/100ps
`default_nettype none

module dma_top
  import dma_pkg::*;
#(
  parameter int ADDR_WIDTH = 32,
  parameter int DATA_WIDTH = 32,
  parameter int MEM_WORDS  = 256
) (
  input  logic                  clk,
  input  logic                  rst,
  // AXI4-Lite slave
  input  logic                  awvalid,
  output logic                  awready,
  input  logic [ADDR_WIDTH-1:0] awaddr,
  input  logic                  wvalid,
  output logic                  wready,
  input  logic [DATA_WIDTH-1:0] wdata,
  output logic                  bvalid,
  input  logic                  bready,
  output logic [1:0]            bresp,
  input  logic                  arvalid,
  output logic                  arready,
  input  logic [ADDR_WIDTH-1:0] araddr,
  output logic                  rvalid,
  input  logic                  rready,
  output logic [DATA_WIDTH-1:0] rdata,
  output logic [1:0]            rresp,
  // Channel streams
  output logic                  s0_data_valid,
  output logic [DATA_WIDTH-1:0] s0_data,
  input  logic                  s0_data_ready,
  output logic                  s1_data_valid,
  output logic [DATA_WIDTH-1:0] s1_data,
  input  logic                  s1_data_ready
);

  // Channel controls
  logic                         ch0_start;
  logic                         ch1_start;
  logic [ADDR_WIDTH-1:0]        ch0_laddr;
  logic [ADDR_WIDTH-1:0]        ch1_laddr;
  logic [DMA_SIZE_WIDTH-1:0]    ch0_size;
  logic [DMA_SIZE_WIDTH-1:0]    ch1_size;
  logic                         ch0_idle;
  logic                         ch1_idle;

  // Engine buses
  logic                         m0_hsel;
  logic                         m1_hsel;
  logic [ADDR_WIDTH-1:0]        m0_haddr;
  logic [ADDR_WIDTH-1:0]        m1_haddr;
  logic [2:0]                   m0_hburst;
  logic [2:0]                   m1_hburst;
  logic                         m0_hmastlock;
  logic                         m1_hmastlock;
  logic [DATA_WIDTH-1:0]        m0_hrdata;
  logic [DATA_WIDTH-1:0]        m1_hrdata;
  logic                         m0_hready;
  logic                         m1_hready;

  // Memory side
  logic                         s_hsel;
  logic [ADDR_WIDTH-1:0]        s_haddr;
  logic [DATA_WIDTH-1:0]        s_hrdata;
  logic                         s_hready;
  logic                         mem_wr_en;
  logic [$clog2(MEM_WORDS)-1:0] mem_wr_index;
  logic [DATA_WIDTH-1:0]        mem_wr_data;

  dma_ctrl_regs #(
    .ADDR_WIDTH(ADDR_WIDTH),
    .DATA_WIDTH(DATA_WIDTH),
    .MEM_WORDS (MEM_WORDS)
  ) u_ctrl (
    .clk           (clk),
    .rst           (rst),
    .awvalid       (awvalid),
    .awready       (awready),
    .awaddr        (awaddr),
    .wvalid        (wvalid),
    .wready        (wready),
    .wdata         (wdata),
    .bvalid        (bvalid),
    .bready        (bready),
    .bresp         (bresp),
    .arvalid       (arvalid),
    .arready       (arready),
    .araddr        (araddr),
    .rvalid        (rvalid),
    .rready        (rready),
    .rdata         (rdata),
    .rresp         (rresp),
    .ch0_start     (ch0_start),
    .ch0_laddr     (ch0_laddr),
    .ch0_size      (ch0_size),
    .ch0_idle      (ch0_idle),
    .ch0_fifo_empty(~s0_data_valid),
    .ch1_start     (ch1_start),
    .ch1_laddr     (ch1_laddr),
    .ch1_size      (ch1_size),
    .ch1_idle      (ch1_idle),
    .ch1_fifo_empty(~s1_data_valid),
    .mem_wr_en     (mem_wr_en),
    .mem_wr_index  (mem_wr_index),
    .mem_wr_data   (mem_wr_data)
  );

  //////////////////////////////
  // Read engines
  //////////////////////////////

  dma_read_engine #(
    .ADDR_WIDTH(ADDR_WIDTH),
    .DATA_WIDTH(DATA_WIDTH)
  ) u_eng0 (
    .clk       (clk),
    .rst       (rst),
    .start     (ch0_start),
    .laddr     (ch0_laddr),
    .size      (ch0_size),
    .idle      (ch0_idle),
    .hsel      (m0_hsel),
    .haddr     (m0_haddr),
    .hburst    (m0_hburst),
    .hmastlock (m0_hmastlock),
    .hrdata    (m0_hrdata),
    .hready    (m0_hready),
    .data_valid(s0_data_valid),
    .data      (s0_data),
    .data_ready(s0_data_ready)
  );

  dma_read_engine #(
    .ADDR_WIDTH(ADDR_WIDTH),
    .DATA_WIDTH(DATA_WIDTH)
  ) u_eng1 (
    .clk       (clk),
    .rst       (rst),
    .start     (ch1_start),
    .laddr     (ch1_laddr),
    .size      (ch1_size),
    .idle      (ch1_idle),
    .hsel      (m1_hsel),
    .haddr     (m1_haddr),
    .hburst    (m1_hburst),
    .hmastlock (m1_hmastlock),
    .hrdata    (m1_hrdata),
    .hready    (m1_hready),
    .data_valid(s1_data_valid),
    .data      (s1_data),
    .data_ready(s1_data_ready)
  );

  //////////////////////////////
  // Shared memory bus
  //////////////////////////////

  dma_bus_arbiter #(
    .ADDR_WIDTH(ADDR_WIDTH),
    .DATA_WIDTH(DATA_WIDTH)
  ) u_arb (
    .clk         (clk),
    .rst         (rst),
    .m0_hsel     (m0_hsel),
    .m0_haddr    (m0_haddr),
    .m0_hburst   (m0_hburst),
    .m0_hmastlock(m0_hmastlock),
    .m0_hrdata   (m0_hrdata),
    .m0_hready   (m0_hready),
    .m1_hsel     (m1_hsel),
    .m1_haddr    (m1_haddr),
    .m1_hburst   (m1_hburst),
    .m1_hmastlock(m1_hmastlock),
    .m1_hrdata   (m1_hrdata),
    .m1_hready   (m1_hready),
    .s_hsel      (s_hsel),
    .s_haddr     (s_haddr),
    .s_hrdata    (s_hrdata),
    .s_hready    (s_hready)
  );

  dma_local_mem #(
    .ADDR_WIDTH(ADDR_WIDTH),
    .DATA_WIDTH(DATA_WIDTH),
    .MEM_WORDS (MEM_WORDS)
  ) u_mem (
    .clk     (clk),
    .rst     (rst),
    .hsel    (s_hsel),
    .haddr   (s_haddr),
    .hrdata  (s_hrdata),
    .hready  (s_hready),
    .wr_en   (mem_wr_en),
    .wr_index(mem_wr_index),
    .wr_data (mem_wr_data)
  );

endmodule

`default_nettype wire

/* tb/tb_dma_top.sv */
`timescale 1ns/100ps
`default_nettype none

module tb_dma_top
  import dma_pkg::*;
();

  localparam int ADDR_WIDTH = 32;
  localparam int DATA_WIDTH = 32;
  localparam int MEM_WORDS  = 256;
  localparam int CLK_PERIOD = 40;
  localparam int TIMEOUT    = 2000;
  localparam int POLL_LIMIT = 200;

  // Stream sink ready modes
  localparam int SINK_ON     = 0;
  localparam int SINK_RANDOM = 1;
  localparam int SINK_STALL  = 2;

  // Base of the memory window on the host bus
  localparam logic [ADDR_WIDTH-1:0] WIN_BASE = 32'(1) << DMA_MEM_WINDOW_BIT;

  logic                  clk;
  logic                  rst;
  logic                  awvalid;
  logic                  awready;
  logic [ADDR_WIDTH-1:0] awaddr;
  logic                  wvalid;
  logic                  wready;
  logic [DATA_WIDTH-1:0] wdata;
  logic                  bvalid;
  logic                  bready;
  logic [1:0]            bresp;
  logic                  arvalid;
  logic                  arready;
  logic [ADDR_WIDTH-1:0] araddr;
  logic                  rvalid;
  logic                  rready;
  logic [DATA_WIDTH-1:0] rdata;
  logic [1:0]            rresp;
  logic                  s0_data_valid;
  logic [DATA_WIDTH-1:0] s0_data;
  logic                  s0_data_ready;
  logic                  s1_data_valid;
  logic [DATA_WIDTH-1:0] s1_data;
  logic                  s1_data_ready;

  // Reference copy of the local memory as the host wrote it
  logic [DATA_WIDTH-1:0] mem_model [MEM_WORDS];
  // Words seen on each stream in arrival order
  logic [DATA_WIDTH-1:0] recv0 [$];
  logic [DATA_WIDTH-1:0] recv1 [$];

  logic [31:0] data_state;
  logic [31:0] ready_state;
  int          mode0;
  int          mode1;
  int          errors;
  int          checks;
  int          tests;
  int          test_errors;
  string       test_name;

  dma_top #(
    .ADDR_WIDTH(ADDR_WIDTH),
    .DATA_WIDTH(DATA_WIDTH),
    .MEM_WORDS (MEM_WORDS)
  ) DUT (
    .clk          (clk),
    .rst          (rst),
    .awvalid      (awvalid),
    .awready      (awready),
    .awaddr       (awaddr),
    .wvalid       (wvalid),
    .wready       (wready),
    .wdata        (wdata),
    .bvalid       (bvalid),
    .bready       (bready),
    .bresp        (bresp),
    .arvalid      (arvalid),
    .arready      (arready),
    .araddr       (araddr),
    .rvalid       (rvalid),
    .rready       (rready),
    .rdata        (rdata),
    .rresp        (rresp),
    .s0_data_valid(s0_data_valid),
    .s0_data      (s0_data),
    .s0_data_ready(s0_data_ready),
    .s1_data_valid(s1_data_valid),
    .s1_data      (s1_data),
    .s1_data_ready(s1_data_ready)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  //////////////////////////////
  // Helpers
  //////////////////////////////

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  // Ready level for one sink from its mode and two random bits
  function automatic logic pick_ready(input int mode, input logic [1:0] bits);
    if (mode == SINK_ON) begin
      return 1'b1;
    end else if (mode == SINK_RANDOM) begin
      // Ready about one cycle in four keeps the FIFO filling up
      return &bits;
    end
    return 1'b0;
  endfunction

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("mismatch at %0t: %s got %h, expected %h", $time, name, got, exp);
    end
  endtask

  task automatic report_failure(input string what);
    errors++;
    $display("failure at %0t: %s", $time, what);
  endtask

  task automatic begin_test(input string name);
    test_name   = name;
    test_errors = errors;
    tests++;
  endtask

  task automatic end_test();
    $display("test %0d %s: %s", tests, test_name, (errors == test_errors) ? "ok" : "failed");
  endtask

  //////////////////////////////
  // Stream sinks
  //////////////////////////////

  // Ready changes on the falling edge and a word counts when valid and ready
  // both hold up to the next rising edge
  always @(negedge clk) begin
    if (rst) begin
      s0_data_ready = 1'b0;
      s1_data_ready = 1'b0;
    end else begin
      ready_state   = xorshift32(ready_state);
      s0_data_ready = pick_ready(mode0, {ready_state[3], ready_state[7]});
      s1_data_ready = pick_ready(mode1, {ready_state[11], ready_state[19]});
      if (s0_data_valid && s0_data_ready) begin
        recv0.push_back(s0_data);
      end
      if (s1_data_valid && s1_data_ready) begin
        recv1.push_back(s1_data);
      end
    end
  end

  //////////////////////////////
  // AXI4-Lite host
  //////////////////////////////

  task automatic axi_write(input logic [31:0] addr, input logic [31:0] value);
    int cnt;
    @(negedge clk);
    awvalid = 1'b1;
    wvalid  = 1'b1;
    awaddr  = addr;
    wdata   = value;
    cnt     = 0;
    // Ready lines follow the valids within the same cycle
    #(CLK_PERIOD / 4);
    check_value("awready", 32'(awready), 32'h1);
    check_value("wready", 32'(wready), 32'h1);
    // bvalid shows up the cycle after the handshake
    @(negedge clk);
    while (!bvalid && cnt < TIMEOUT) begin
      @(negedge clk);
      cnt++;
    end
    awvalid = 1'b0;
    wvalid  = 1'b0;
    if (!bvalid) begin
      report_failure($sformatf("no write response for address %h", addr));
    end else begin
      check_value("bresp", 32'(bresp), 32'h0);
      bready = 1'b1;
      @(negedge clk);
      bready = 1'b0;
      check_value("bvalid after bready", 32'(bvalid), 32'h0);
    end
  endtask

  task automatic axi_read(input logic [31:0] addr, output logic [31:0] value);
    int cnt;
    value = '0;
    @(negedge clk);
    // No read response is pending here
    check_value("arready", 32'(arready), 32'h1);
    arvalid = 1'b1;
    araddr  = addr;
    cnt     = 0;
    @(negedge clk);
    while (!rvalid && cnt < TIMEOUT) begin
      @(negedge clk);
      cnt++;
    end
    arvalid = 1'b0;
    if (!rvalid) begin
      report_failure($sformatf("no read response for address %h", addr));
    end else begin
      value = rdata;
      check_value("rresp", 32'(rresp), 32'h0);
      rready = 1'b1;
      @(negedge clk);
      rready = 1'b0;
    end
  endtask

  task automatic reg_write(input int ch, input logic [3:0] ofs, input logic [31:0] value);
    axi_write(32'(ch * DMA_CH_STRIDE) | {28'h0, ofs}, value);
  endtask

  task automatic reg_read(input int ch, input logic [3:0] ofs, output logic [31:0] value);
    axi_read(32'(ch * DMA_CH_STRIDE) | {28'h0, ofs}, value);
  endtask

  // Random words into the window and the reference copy
  task automatic load_words(input int first, input int count);
    for (int i = 0; i < count; i++) begin
      data_state            = xorshift32(data_state);
      mem_model[first + i]  = data_state;
      axi_write(WIN_BASE + 32'((first + i) * 4), data_state);
    end
  endtask

  task automatic start_channel(input int ch, input int first, input int count);
    reg_write(ch, DMA_REG_LADDR, 32'(first * 4));
    reg_write(ch, DMA_REG_SIZE, 32'(count));
    reg_write(ch, DMA_REG_CTRL, 32'h1);
  endtask

  task automatic wait_words(input int ch, input int count);
    int cnt;
    cnt = 0;
    while (((ch == 0) ? recv0.size() : recv1.size()) < count && cnt < TIMEOUT) begin
      @(negedge clk);
      cnt++;
    end
    if (cnt >= TIMEOUT) begin
      report_failure($sformatf("stream %0d stopped before %0d words", ch, count));
    end
  endtask

  // Poll CTRL until the busy flag reads the wanted level
  task automatic wait_busy(input int ch, input logic level);
    logic [31:0] value;
    int          polls;
    polls = 0;
    reg_read(ch, DMA_REG_CTRL, value);
    while (value[0] !== level && polls < POLL_LIMIT) begin
      reg_read(ch, DMA_REG_CTRL, value);
      polls++;
    end
    if (value[0] !== level) begin
      report_failure($sformatf("channel %0d busy flag never read %0d", ch, level));
    end
  endtask

  task automatic check_stream(input int ch, input int first, input int count);
    int                    n;
    logic [DATA_WIDTH-1:0] got;
    n = (ch == 0) ? recv0.size() : recv1.size();
    check_value($sformatf("s%0d word count", ch), 32'(n), 32'(count));
    for (int i = 0; i < n && i < count; i++) begin
      got = (ch == 0) ? recv0[i] : recv1[i];
      check_value($sformatf("s%0d_data[%0d]", ch, i), got, mem_model[first + i]);
    end
  endtask

  //////////////////////////////
  // Tests
  //////////////////////////////

  task automatic test_reset_state();
    logic [31:0] value;
    begin_test("reset state");
    check_value("awready", 32'(awready), 32'h0);
    check_value("arready", 32'(arready), 32'h0);
    check_value("bvalid", 32'(bvalid), 32'h0);
    check_value("rvalid", 32'(rvalid), 32'h0);
    check_value("s0_data_valid", 32'(s0_data_valid), 32'h0);
    check_value("s1_data_valid", 32'(s1_data_valid), 32'h0);
    reg_read(0, DMA_REG_CTRL, value);
    check_value("ch0 ctrl", value, 32'h0);
    reg_read(1, DMA_REG_CTRL, value);
    check_value("ch1 ctrl", value, 32'h0);
    end_test();
  endtask

  task automatic test_single_burst();
    begin_test("channel 0 burst");
    load_words(0, 16);
    mode0 = SINK_ON;
    recv0.delete();
    start_channel(0, 0, 16);
    wait_words(0, 16);
    wait_busy(0, 1'b0);
    check_stream(0, 0, 16);
    end_test();
  endtask

  task automatic test_backpressure();
    begin_test("channel 1 back-pressure");
    load_words(0, 16);
    mode1 = SINK_RANDOM;
    recv1.delete();
    start_channel(1, 0, 16);
    wait_words(1, 16);
    wait_busy(1, 1'b0);
    check_stream(1, 0, 16);
    end_test();
  endtask

  task automatic test_dual_channel();
    begin_test("both channels");
    load_words(32, 16);
    load_words(64, 24);
    mode0 = SINK_ON;
    mode1 = SINK_RANDOM;
    recv0.delete();
    recv1.delete();
    // Channel 1 starts while channel 0 still holds the bus
    start_channel(0, 32, 16);
    start_channel(1, 64, 24);
    wait_words(0, 16);
    wait_words(1, 24);
    wait_busy(0, 1'b0);
    wait_busy(1, 1'b0);
    check_stream(0, 32, 16);
    check_stream(1, 64, 24);
    end_test();
  endtask

  task automatic test_ignored_start();
    logic [31:0] value;
    begin_test("ignored starts");
    load_words(100, 2);
    mode0 = SINK_STALL;
    recv0.delete();
    recv1.delete();
    // Stalled sink keeps both words in the FIFO
    // Channel 0 stays busy while its engine is already idle
    start_channel(0, 100, 2);
    wait_busy(0, 1'b1);
    // Channel 1 with a zero length
    reg_write(1, DMA_REG_LADDR, 32'h0000_0140);
    reg_write(1, DMA_REG_SIZE, 32'h0);
    reg_write(1, DMA_REG_CTRL, 32'h1);
    // Second start on the busy channel
    reg_write(0, DMA_REG_CTRL, 32'h1);
    reg_read(0, DMA_REG_LADDR, value);
    check_value("ch0 laddr", value, 32'd400);
    reg_read(0, DMA_REG_SIZE, value);
    check_value("ch0 size", value, 32'd2);
    reg_read(1, DMA_REG_LADDR, value);
    check_value("ch1 laddr", value, 32'h0000_0140);
    reg_read(1, DMA_REG_SIZE, value);
    check_value("ch1 size", value, 32'h0);
    reg_read(1, DMA_REG_CTRL, value);
    check_value("ch1 ctrl", value, 32'h0);
    mode0 = SINK_ON;
    wait_words(0, 2);
    wait_busy(0, 1'b0);
    // Extra words would show up here
    repeat (40) @(negedge clk);
    check_stream(0, 100, 2);
    check_value("s1 word count", 32'(recv1.size()), 32'h0);
    end_test();
  endtask

  initial begin
    rst         = 1'b1;
    awvalid     = 1'b0;
    awaddr      = '0;
    wvalid      = 1'b0;
    wdata       = '0;
    bready      = 1'b0;
    arvalid     = 1'b0;
    araddr      = '0;
    rready      = 1'b0;
    s0_data_ready = 1'b0;
    s1_data_ready = 1'b0;
    data_state  = 32'd28262;
    ready_state = xorshift32(32'd28262);
    mode0       = SINK_ON;
    mode1       = SINK_ON;
    errors      = 0;
    checks      = 0;
    tests       = 0;
    repeat (5) @(negedge clk);
    rst = 1'b0;

    test_reset_state();
    test_single_burst();
    test_backpressure();
    test_dual_channel();
    test_ignored_start();

    $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
    if (errors == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule

`default_nettype wire
